//--- hw/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

`define ISSUE_LANES      2
`define DISPATCH_SLOTS   2
`define IQ_DEPTH         8
`define PHY_ID_WIDTH     6
`define DATA_WIDTH       32
`define ROB_ID_WIDTH     5
`define FB_CHANNELS      2
`define ALU_UNITS        2
// port order is ALU0..ALUn, MUL, LSU
`define UNIT_PORTS       (`ALU_UNITS + 2)

`define UNIT_CODE_WIDTH  2
`define UNIT_ALU         2'd0
`define UNIT_MUL         2'd1
`define UNIT_LSU         2'd2

`define CNT_WIDTH        32
`define REG_STALL_CNT    4'h0
`define REG_BLOCK_CNT    4'h4
`define REG_DISPATCH_CNT 4'h8
`define REG_CLEAR        4'hc

`endif

//--- hw/issue_pkg.sv
`default_nettype none

`include "issue_macros.svh"

package issue_pkg;

    typedef logic [`PHY_ID_WIDTH-1:0] phy_id_t;
    typedef logic [`DATA_WIDTH-1:0] reg_data_t;
    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [`UNIT_CODE_WIDTH-1:0] unit_code_t;
    typedef logic [`CNT_WIDTH-1:0] cnt_t;
    typedef logic [3:0] apb_addr_t;

    // lane offset, per-bundle push count, queue pointer and occupancy
    typedef logic [$clog2(`ISSUE_LANES)-1:0] lane_idx_t;
    typedef logic [$clog2(`ISSUE_LANES):0] lane_cnt_t;
    typedef logic [$clog2(`IQ_DEPTH)-1:0] iq_ptr_t;
    typedef logic [$clog2(`IQ_DEPTH):0] iq_cnt_t;
    typedef logic [$clog2(`DISPATCH_SLOTS):0] pop_cnt_t;

    typedef struct packed {
        phy_id_t   phy_id;
        reg_data_t value;
        logic      loaded;
    } src_operand_t;

    typedef struct packed {
        logic         enable;
        rob_id_t      rob_id;
        unit_code_t   unit;
        src_operand_t src1;
        src_operand_t src2;
        phy_id_t      rd_phy;
    } issue_op_t;

    typedef struct packed {
        logic      enable;
        phy_id_t   phy_id;
        reg_data_t value;
    } feedback_chan_t;

    typedef struct packed {
        reg_data_t data;
        logic      valid;
    } regfile_rsp_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        reg_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        reg_data_t prdata;
        logic      pready;
    } apb_rsp_t;

    // lowest channel index wins when several match
    function automatic src_operand_t fb_wakeup(input src_operand_t src,
                                               input feedback_chan_t fb [0:`FB_CHANNELS-1]);
        src_operand_t res;
        res = src;
        for (int c = 0; c < `FB_CHANNELS; c++) begin
            if (!res.loaded && fb[c].enable && fb[c].phy_id == src.phy_id) begin
                res.value  = fb[c].value;
                res.loaded = 1'b1;
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- hw/operand_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module operand_capture import issue_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  issue_op_t      in_ops          [0:`ISSUE_LANES-1],
    output phy_id_t        regfile_read_id [0:`ISSUE_LANES-1][0:1],
    input  regfile_rsp_t   regfile_rsp     [0:`ISSUE_LANES-1][0:1],
    input  feedback_chan_t fb              [0:`FB_CHANNELS-1],
    input  iq_cnt_t        free_slots,
    input  logic           flush,
    output issue_op_t      push_ops        [0:`ISSUE_LANES-1],
    output logic [`ISSUE_LANES-1:0] push_valid,
    output logic           stall
);

    issue_op_t captured [0:`ISSUE_LANES-1];
    issue_op_t view     [0:`ISSUE_LANES-1];
    logic [`ISSUE_LANES-1:0] view_en;
    lane_idx_t lane_offset;
    lane_cnt_t push_num;

    // carried value first, then register file, then bypass
    always_comb begin
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            regfile_read_id[i][0] = in_ops[i].src1.phy_id;
            regfile_read_id[i][1] = in_ops[i].src2.phy_id;

            captured[i] = in_ops[i];
            if (!captured[i].src1.loaded && regfile_rsp[i][0].valid) begin
                captured[i].src1.value  = regfile_rsp[i][0].data;
                captured[i].src1.loaded = 1'b1;
            end
            if (!captured[i].src2.loaded && regfile_rsp[i][1].valid) begin
                captured[i].src2.value  = regfile_rsp[i][1].data;
                captured[i].src2.loaded = 1'b1;
            end
            captured[i].src1 = fb_wakeup(captured[i].src1, fb);
            captured[i].src2 = fb_wakeup(captured[i].src2, fb);
        end
    end

    // shift the bundle so that lanes left over from a partial push come first
    always_comb begin
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            if (i + int'(lane_offset) < `ISSUE_LANES) begin
                view[i] = captured[i + int'(lane_offset)];
            end else begin
                view[i] = '0;
            end
            view_en[i] = view[i].enable;
        end
    end

    always_comb begin
        int used;
        used     = 0;
        push_num = '0;
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            push_ops[i]   = view[i];
            push_valid[i] = 1'b0;
            if (view_en[i]) begin
                used = used + 1;
                if (used <= int'(free_slots) && !flush) begin
                    push_valid[i] = 1'b1;
                    push_num      = push_num + 1'b1;
                end
            end
        end
    end

    assign stall = !flush && ((view_en & push_valid) != view_en);

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_offset <= '0;
        end else if (!stall) begin
            lane_offset <= '0;
        end else begin
            lane_offset <= lane_offset + lane_idx_t'(push_num);
        end
    end

endmodule

`default_nettype wire

//--- hw/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module issue_queue import issue_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  issue_op_t      push_ops   [0:`ISSUE_LANES-1],
    input  logic [`ISSUE_LANES-1:0] push_valid,
    input  pop_cnt_t       pop_count,
    input  logic           flush,
    input  feedback_chan_t fb         [0:`FB_CHANNELS-1],
    output iq_cnt_t        free_slots,
    output issue_op_t      head_ops   [0:`DISPATCH_SLOTS-1],
    output logic [`DISPATCH_SLOTS-1:0] head_valid
);

    issue_op_t mem [0:`IQ_DEPTH-1];
    iq_ptr_t   head_ptr;
    iq_ptr_t   tail_ptr;
    iq_cnt_t   count;
    iq_ptr_t   wr_idx [0:`ISSUE_LANES-1];
    lane_cnt_t push_num;

    // valid lanes are packed into consecutive slots from the tail
    always_comb begin
        push_num = '0;
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            wr_idx[i] = tail_ptr + iq_ptr_t'(push_num);
            if (push_valid[i]) begin
                push_num = push_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            head_ptr <= head_ptr + iq_ptr_t'(pop_count);
            tail_ptr <= tail_ptr + iq_ptr_t'(push_num);
            count    <= count + iq_cnt_t'(push_num) - iq_cnt_t'(pop_count);
        end
    end

    // wakeup on every stored entry, new writes land in free slots only
    always_ff @(posedge clk) begin
        for (int e = 0; e < `IQ_DEPTH; e++) begin
            mem[e].src1 <= fb_wakeup(mem[e].src1, fb);
            mem[e].src2 <= fb_wakeup(mem[e].src2, fb);
        end
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            if (push_valid[i]) begin
                mem[wr_idx[i]] <= push_ops[i];
            end
        end
    end

    assign free_slots = iq_cnt_t'(`IQ_DEPTH) - count;

    always_comb begin
        for (int s = 0; s < `DISPATCH_SLOTS; s++) begin
            head_ops[s]   = mem[head_ptr + iq_ptr_t'(s)];
            head_valid[s] = count > iq_cnt_t'(s);
        end
    end

endmodule

`default_nettype wire

//--- hw/unit_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module unit_dispatch import issue_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  issue_op_t head_ops   [0:`DISPATCH_SLOTS-1],
    input  logic [`DISPATCH_SLOTS-1:0] head_valid,
    input  logic [`UNIT_PORTS-1:0] unit_full,
    input  logic      flush,
    output logic [`UNIT_PORTS-1:0] unit_push,
    output issue_op_t unit_data  [0:`UNIT_PORTS-1],
    output logic [`UNIT_PORTS-1:0] unit_flush,
    output pop_cnt_t  pop_count,
    output logic      blocked
);

    localparam int MUL_PORT  = `ALU_UNITS;
    localparam int LSU_PORT  = `ALU_UNITS + 1;
    localparam int ALU_PTR_W = ($clog2(`ALU_UNITS) > 0) ? $clog2(`ALU_UNITS) : 1;

    typedef logic [ALU_PTR_W-1:0] alu_ptr_t;

    alu_ptr_t alu_ptr;
    pop_cnt_t alu_sent;

    always_comb begin
        logic go;
        logic route_ok;
        int   port;
        go        = !flush;
        pop_count = '0;
        alu_sent  = '0;
        blocked   = 1'b0;
        unit_push = '0;
        for (int p = 0; p < `UNIT_PORTS; p++) begin
            unit_data[p] = '0;
        end
        for (int s = 0; s < `DISPATCH_SLOTS; s++) begin
            route_ok = 1'b1;
            case (head_ops[s].unit)
                `UNIT_ALU: port = (int'(alu_ptr) + int'(alu_sent)) % `ALU_UNITS;
                `UNIT_MUL: port = MUL_PORT;
                `UNIT_LSU: port = LSU_PORT;
                default: begin
                    port     = 0;
                    route_ok = 1'b0;
                end
            endcase
            // one push per port per cycle, a second op for the same port waits
            if (go && head_valid[s] && route_ok && head_ops[s].src1.loaded
                    && head_ops[s].src2.loaded && !unit_full[port] && !unit_push[port]) begin
                unit_push[port] = 1'b1;
                unit_data[port] = head_ops[s];
                pop_count       = pop_count + 1'b1;
                if (head_ops[s].unit == `UNIT_ALU) begin
                    alu_sent = alu_sent + 1'b1;
                end
            end else begin
                go = 1'b0;
                if (head_valid[s] && !flush) begin
                    blocked = 1'b1;
                end
            end
        end
    end

    assign unit_flush = {`UNIT_PORTS{flush}};

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_ptr <= '0;
        end else begin
            alu_ptr <= alu_ptr_t'((int'(alu_ptr) + int'(alu_sent)) % `ALU_UNITS);
        end
    end

endmodule

`default_nettype wire

//--- hw/issue_perf_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module issue_perf_regs import issue_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     stall,
    input  logic     blocked,
    input  pop_cnt_t pop_count
);

    cnt_t stall_cnt;
    cnt_t block_cnt;
    cnt_t dispatch_cnt;
    logic clear_hit;

    // clear takes effect in the access phase, whatever the write data
    assign clear_hit = apb_req.psel && apb_req.penable && apb_req.pwrite
                       && apb_req.paddr == `REG_CLEAR;

    always_ff @(posedge clk) begin
        if (rst || clear_hit) begin
            stall_cnt    <= '0;
            block_cnt    <= '0;
            dispatch_cnt <= '0;
        end else begin
            stall_cnt    <= stall_cnt + cnt_t'(stall);
            block_cnt    <= block_cnt + cnt_t'(blocked);
            dispatch_cnt <= dispatch_cnt + cnt_t'(pop_count);
        end
    end

    // no wait states
    always_comb begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = '0;
        if (apb_req.psel && !apb_req.pwrite) begin
            case (apb_req.paddr)
                `REG_STALL_CNT:    apb_rsp.prdata = stall_cnt;
                `REG_BLOCK_CNT:    apb_rsp.prdata = block_cnt;
                `REG_DISPATCH_CNT: apb_rsp.prdata = dispatch_cnt;
                default:           apb_rsp.prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module issue_stage import issue_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  issue_op_t      in_ops          [0:`ISSUE_LANES-1],
    output logic           stall,
    output phy_id_t        regfile_read_id [0:`ISSUE_LANES-1][0:1],
    input  regfile_rsp_t   regfile_rsp     [0:`ISSUE_LANES-1][0:1],
    input  feedback_chan_t fb              [0:`FB_CHANNELS-1],
    input  logic           flush,
    input  logic [`UNIT_PORTS-1:0] unit_full,
    output logic [`UNIT_PORTS-1:0] unit_push,
    output issue_op_t      unit_data       [0:`UNIT_PORTS-1],
    output logic [`UNIT_PORTS-1:0] unit_flush,
    input  apb_req_t       apb_req,
    output apb_rsp_t       apb_rsp
);

    issue_op_t push_ops [0:`ISSUE_LANES-1];
    logic [`ISSUE_LANES-1:0] push_valid;
    iq_cnt_t   free_slots;
    issue_op_t head_ops [0:`DISPATCH_SLOTS-1];
    logic [`DISPATCH_SLOTS-1:0] head_valid;
    pop_cnt_t  pop_count;
    logic      blocked;

    operand_capture u_capture (
        .clk             (clk),
        .rst             (rst),
        .in_ops          (in_ops),
        .regfile_read_id (regfile_read_id),
        .regfile_rsp     (regfile_rsp),
        .fb              (fb),
        .free_slots      (free_slots),
        .flush           (flush),
        .push_ops        (push_ops),
        .push_valid      (push_valid),
        .stall           (stall)
    );

    issue_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .push_ops   (push_ops),
        .push_valid (push_valid),
        .pop_count  (pop_count),
        .flush      (flush),
        .fb         (fb),
        .free_slots (free_slots),
        .head_ops   (head_ops),
        .head_valid (head_valid)
    );

    unit_dispatch u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .head_ops   (head_ops),
        .head_valid (head_valid),
        .unit_full  (unit_full),
        .flush      (flush),
        .unit_push  (unit_push),
        .unit_data  (unit_data),
        .unit_flush (unit_flush),
        .pop_count  (pop_count),
        .blocked    (blocked)
    );

    issue_perf_regs u_perf (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .stall     (stall),
        .blocked   (blocked),
        .pop_count (pop_count)
    );

endmodule

`default_nettype wire

//--- verification/issue_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module issue_checker import issue_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic [`UNIT_PORTS-1:0] unit_full,
    input logic [`UNIT_PORTS-1:0] unit_push,
    input logic [`UNIT_PORTS-1:0] unit_flush,
    input issue_op_t              unit_data [0:`UNIT_PORTS-1]
);

    // expected operations per unit port, oldest first
    issue_op_t exp_q [0:`UNIT_PORTS-1][$];
    int        errors;
    int        push_total;
    int        queued_total;
    logic      flush_seen;

    initial begin
        errors       = 0;
        push_total   = 0;
        queued_total = 0;
        flush_seen   = 1'b0;
    end

    task automatic queue_expected(input int port, input issue_op_t op);
        exp_q[port].push_back(op);
        queued_total++;
    endtask

    function automatic int pending_total();
        int n;
        n = 0;
        for (int p = 0; p < `UNIT_PORTS; p++) begin
            n = n + exp_q[p].size();
        end
        return n;
    endfunction

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // inputs change on the falling edge, so the rising edge sees settled outputs
    always @(posedge clk) begin
        issue_op_t want;
        if (!rst) begin
            if (unit_flush == '1) begin
                flush_seen = 1'b1;
            end
            for (int p = 0; p < `UNIT_PORTS; p++) begin
                if (unit_push[p]) begin
                    push_total++;
                    if (unit_full[p]) begin
                        report_failure($sformatf("push on port %0d while it was full", p));
                    end
                    if (exp_q[p].size() == 0) begin
                        report_failure($sformatf("unexpected push on port %0d", p));
                    end else begin
                        want = exp_q[p].pop_front();
                        if (unit_data[p] !== want) begin
                            $display("MISMATCH at %0t: unit_data[%0d] got %h expected %h",
                                     $time, p, unit_data[p], want);
                            errors++;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module tb_issue_stage import issue_pkg::*; ();

    // estimated cycles per test, summed
    localparam int TEST_LEN = 60 + 80 + 120 + 40 + 40 + 30;

    logic           clk;
    logic           rst;
    logic           stall;
    logic           flush;
    issue_op_t      in_ops          [0:`ISSUE_LANES-1];
    phy_id_t        regfile_read_id [0:`ISSUE_LANES-1][0:1];
    regfile_rsp_t   regfile_rsp     [0:`ISSUE_LANES-1][0:1];
    feedback_chan_t fb              [0:`FB_CHANNELS-1];
    logic [`UNIT_PORTS-1:0] unit_full;
    logic [`UNIT_PORTS-1:0] unit_push;
    logic [`UNIT_PORTS-1:0] unit_flush;
    issue_op_t      unit_data       [0:`UNIT_PORTS-1];
    apb_req_t       apb_req;
    apb_rsp_t       apb_rsp;
    issue_op_t      exp_ops         [0:`ISSUE_LANES-1];
    int             alu_count;
    int             rob_next;
    int             tests_run;
    int             tests_failed;
    int             err_before;
    int             base;
    logic           stall_seen;
    phy_id_t        p;
    reg_data_t      rd;

    issue_stage uut (
        .clk(clk), .rst(rst), .in_ops(in_ops), .stall(stall),
        .regfile_read_id(regfile_read_id), .regfile_rsp(regfile_rsp), .fb(fb),
        .flush(flush), .unit_full(unit_full), .unit_push(unit_push),
        .unit_data(unit_data), .unit_flush(unit_flush), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    issue_checker chk (
        .clk(clk), .rst(rst), .unit_full(unit_full), .unit_push(unit_push),
        .unit_flush(unit_flush), .unit_data(unit_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TEST_LEN * 4) @(posedge clk);
        $display("watchdog timeout: the run did not finish in time");
        $display("tests failed");
        $finish;
    end

    // carried value, then register file, then bypass
    function automatic reg_data_t exp_operand(input logic carried, input reg_data_t cval,
                                              input logic rf_v, input reg_data_t rf_d,
                                              input logic fb_hit, input reg_data_t fb_d);
        if (carried) begin
            return cval;
        end else if (rf_v) begin
            return rf_d;
        end else if (fb_hit) begin
            return fb_d;
        end
        return '0;
    endfunction

    task automatic idle_inputs();
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            in_ops[i]         = '0;
            exp_ops[i]        = '0;
            regfile_rsp[i][0] = '0;
            regfile_rsp[i][1] = '0;
        end
        for (int c = 0; c < `FB_CHANNELS; c++) begin
            fb[c] = '0;
        end
    endtask

    // random carried and regfile sources, fb[0] set by the caller
    task automatic set_lane(input int i, input unit_code_t u, input phy_id_t ph);
        src_operand_t src;
        src_operand_t want;
        issue_op_t    op;
        op.enable = 1'b1;
        op.rob_id = rob_id_t'(rob_next);
        op.unit   = u;
        op.rd_phy = phy_id_t'($urandom);
        rob_next++;
        exp_ops[i] = op;
        for (int s = 0; s < 2; s++) begin
            src.phy_id = ph;
            src.value  = $urandom;
            src.loaded = 1'($urandom_range(0, 1));
            regfile_rsp[i][s].data  = $urandom;
            regfile_rsp[i][s].valid = 1'($urandom_range(0, 1));
            want        = src;
            want.loaded = 1'b1;
            want.value  = exp_operand(src.loaded, src.value, regfile_rsp[i][s].valid,
                                      regfile_rsp[i][s].data,
                                      fb[0].enable && fb[0].phy_id == ph, fb[0].value);
            if (s == 0) begin
                op.src1         = src;
                exp_ops[i].src1 = want;
            end else begin
                op.src2         = src;
                exp_ops[i].src2 = want;
            end
        end
        in_ops[i] = op;
    endtask

    // holds the bundle while stalled, ends on the falling edge after acceptance
    task automatic issue_bundle(input logic record);
        int port;
        #1;
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            if (exp_ops[i].enable) begin
                chk.compare_value($sformatf("regfile_read_id[%0d][0]", i),
                                  32'(regfile_read_id[i][0]), 32'(exp_ops[i].src1.phy_id));
                chk.compare_value($sformatf("regfile_read_id[%0d][1]", i),
                                  32'(regfile_read_id[i][1]), 32'(exp_ops[i].src2.phy_id));
            end
        end
        while (stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
            #1;
        end
        for (int i = 0; i < `ISSUE_LANES; i++) begin
            if (record && exp_ops[i].enable) begin
                case (exp_ops[i].unit)
                    `UNIT_MUL: port = `ALU_UNITS;
                    `UNIT_LSU: port = `ALU_UNITS + 1;
                    default: begin
                        port = alu_count % `ALU_UNITS;
                        alu_count++;
                    end
                endcase
                chk.queue_expected(port, exp_ops[i]);
            end
        end
        @(negedge clk);
    endtask

    task automatic random_bundle(input unit_code_t u0, input unit_code_t u1, input logic record);
        phy_id_t ph;
        idle_inputs();
        ph    = phy_id_t'($urandom);
        fb[0] = '{enable: 1'b1, phy_id: ph, value: $urandom};
        set_lane(0, u0, ph);
        set_lane(1, u1, ph);
        issue_bundle(record);
    endtask

    task automatic drain();
        idle_inputs();
        while (chk.pending_total() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, output reg_data_t data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: '0};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        data = apb_rsp.prdata;
        chk.compare_value("pready", 32'(apb_rsp.pready), 32'd1);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (chk.errors > err_before) begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        err_before = chk.errors;
    endtask

    initial begin
        void'($urandom(32'h2e25_b24a));
        rst = 1'b1;
        flush = 1'b0;
        unit_full = '0;
        apb_req = '0;
        alu_count = 0;
        rob_next = 0;
        tests_run = 0;
        tests_failed = 0;
        err_before = 0;
        stall_seen = 1'b0;
        idle_inputs();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (6) random_bundle(`UNIT_ALU, `UNIT_LSU, 1'b1);
        drain();
        finish_test("capture priority");

        repeat (8) begin
            random_bundle(unit_code_t'($urandom_range(0, 2)),
                          unit_code_t'($urandom_range(0, 2)), 1'b1);
        end
        drain();
        finish_test("in-order dispatch and ALU round-robin");

        unit_full[`ALU_UNITS] = 1'b1;
        base = chk.push_total;
        stall_seen = 1'b0;
        fork
            begin
                repeat (40) @(negedge clk);
                chk.compare_value("push_total", chk.push_total, base);
                chk.compare_value("stall_seen", 32'(stall_seen), 32'd1);
                unit_full = '0;
            end
            begin
                random_bundle(`UNIT_MUL, `UNIT_ALU, 1'b1);
                repeat (5) random_bundle(`UNIT_ALU, `UNIT_ALU, 1'b1);
            end
        join
        drain();
        finish_test("back-pressure");

        // lane 0 waits on src1 until the bypass shows its register
        idle_inputs();
        p  = phy_id_t'($urandom);
        rd = $urandom;
        in_ops[0] = '{enable: 1'b1, rob_id: rob_id_t'(rob_next), unit: `UNIT_ALU,
                      src1: '{phy_id: p, value: '0, loaded: 1'b0},
                      src2: '{phy_id: p + 1'b1, value: 32'h1234, loaded: 1'b1},
                      rd_phy: phy_id_t'($urandom)};
        rob_next++;
        exp_ops[0] = in_ops[0];
        exp_ops[0].src1.value  = exp_operand(1'b0, '0, 1'b0, '0, 1'b1, rd);
        exp_ops[0].src1.loaded = 1'b1;
        issue_bundle(1'b1);
        idle_inputs();
        base = chk.push_total;
        repeat (6) @(negedge clk);
        chk.compare_value("push_total", chk.push_total, base);
        fb[1] = '{enable: 1'b1, phy_id: p, value: rd};
        @(negedge clk);
        drain();
        finish_test("wakeup");

        unit_full = '1;
        base = chk.push_total;
        random_bundle(`UNIT_ALU, `UNIT_MUL, 1'b0);
        random_bundle(`UNIT_LSU, `UNIT_ALU, 1'b0);
        idle_inputs();
        repeat (2) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        unit_full = '0;
        repeat (10) @(negedge clk);
        chk.compare_value("push_total", chk.push_total, base);
        chk.compare_value("unit_flush seen", 32'(chk.flush_seen), 32'd1);
        finish_test("flush");

        apb_access(1'b0, `REG_DISPATCH_CNT, rd);
        chk.compare_value("prdata dispatch_cnt", rd, chk.queued_total);
        apb_access(1'b1, `REG_CLEAR, rd);
        apb_access(1'b0, `REG_DISPATCH_CNT, rd);
        chk.compare_value("prdata dispatch_cnt", rd, 32'd0);
        apb_access(1'b0, `REG_STALL_CNT, rd);
        chk.compare_value("prdata stall_cnt", rd, 32'd0);
        apb_access(1'b0, `REG_BLOCK_CNT, rd);
        chk.compare_value("prdata block_cnt", rd, 32'd0);
        finish_test("counters");

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, chk.errors);
        if (tests_failed == 0 && chk.errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/issue_pkg.sv
hw/operand_capture.sv
hw/issue_queue.sv
hw/unit_dispatch.sv
hw/issue_perf_regs.sv
hw/issue_stage.sv
verification/issue_checker.sv
verification/tb_issue_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator

verilator --binary --timing -f filelist.f --top-module tb_issue_stage -o sim_issue
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

./obj_dir/sim_issue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
